// File: dcache_addr_pkg.sv
`default_nettype none

`include "dcache_config.svh"

package dcache_addr_pkg;

  typedef logic [`DC_TAG_BITS-1:0] dc_tag_t;
  typedef logic [`DC_INDEX_BITS-1:0] dc_index_t;

  // one byte address: flat for the bus and the queue search,
  // split into fields for the array
  typedef union packed {
    logic [`DC_ADDR_BITS-1:0] raw;
    struct packed {
      dc_tag_t                    tag;
      dc_index_t                  index;
      logic [`DC_OFFSET_BITS-1:0] offset;
    } fields;
  } dc_addr_t;

endpackage

`default_nettype wire

// File: dcache_cmd_pkg.sv
`default_nettype none

package dcache_cmd_pkg;

  // load reads then fills clean, store fills dirty, evict writes then retires
  typedef enum logic [1:0] {LOAD, STORE, EVICT} mshr_kind_t;

  typedef enum logic {BUS_LOAD, BUS_STORE} bus_cmd_t;

  // bus operation behind each entry kind
  function automatic bus_cmd_t bus_cmd_of(mshr_kind_t kind);
    return (kind == EVICT) ? BUS_STORE : BUS_LOAD;
  endfunction

endpackage

`default_nettype wire

// File: dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// processor word address, byte address appends the offset
`define DC_WORD_ADDR_BITS 13
`define DC_OFFSET_BITS 3
`define DC_ADDR_BITS (`DC_WORD_ADDR_BITS + `DC_OFFSET_BITS)

// direct-mapped, one 64-bit word per line
`define DC_INDEX_BITS 4
`define DC_TAG_BITS (`DC_ADDR_BITS - `DC_INDEX_BITS - `DC_OFFSET_BITS)
`define DC_LINES (1 << `DC_INDEX_BITS)

// miss queue entries
`define DC_MSHR_DEPTH 4

`endif

// File: dcache_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_controller
  import dcache_addr_pkg::*;
  import dcache_cmd_pkg::*;
(
  input  wire logic                          clock,
  input  wire logic                          reset,
  input  wire logic                          rd_en,
  input  wire logic                          wr_en,
  input  wire logic [`DC_WORD_ADDR_BITS-1:0] rd_addr,
  input  wire logic [`DC_WORD_ADDR_BITS-1:0] wr_addr,
  input  wire logic [63:0]                   wr_data,
  input  wire logic                          write_back,
  input  wire logic [63:0]                   rd1_data,
  input  wire logic                          rd1_hit,
  input  wire logic                          wr1_hit,
  input  wire logic                          evicted_valid,
  input  wire logic                          evicted_dirty,
  input  wire dc_addr_t                      evicted_addr,
  input  wire logic [63:0]                   evicted_data,
  input  wire logic                          mshr_full,
  input  wire logic                          mshr_empty,
  input  wire logic                          search_rd_hit,
  input  wire logic                          search_wr_hit,
  input  wire logic                          fill_valid,
  input  wire dc_addr_t                      fill_addr,
  input  wire logic [63:0]                   fill_data,
  input  wire logic                          fill_dirty,
  output logic [63:0]                        data,
  output logic                               valid_data,
  output logic                               valid_store,
  output logic                               flush_done,
  output dc_addr_t                           rd1_addr,
  output dc_addr_t                           wr1_addr,
  output logic                               wr1_en,
  output logic [63:0]                        wr1_data,
  output logic                               wr1_dirty,
  output logic                               wr1_valid,
  output logic                               push_en,
  output mshr_kind_t                         push_kind,
  output dc_addr_t                           push_addr,
  output logic [63:0]                        push_data,
  output dc_addr_t                           search_rd_addr,
  output dc_addr_t                           search_wr_addr,
  output logic                               fill_taken
);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_SWEEP = 2'd1;
  localparam logic [1:0] ST_DONE  = 2'd2;

  logic [1:0] state;
  dc_index_t  sweep_count;
  dc_addr_t   rd_byte;
  dc_addr_t   wr_byte;
  dc_addr_t   sweep_addr;
  logic       idle;
  logic       store_hit;
  logic       sweep_step;
  logic       fill_direct;
  logic       fill_flush;
  logic       evict_push;
  logic       store_miss;
  logic       load_miss;

  assign rd_byte.raw = {rd_addr, {`DC_OFFSET_BITS{1'b0}}};
  assign wr_byte.raw = {wr_addr, {`DC_OFFSET_BITS{1'b0}}};

  always_comb begin
    sweep_addr              = '0;
    sweep_addr.fields.index = sweep_count;
  end

  assign idle = (state == ST_IDLE);

  // store hits are looked up on the read port, free while wr_en is high
  assign rd1_addr       = wr_en ? wr_byte : rd_byte;
  assign search_rd_addr = rd_byte;
  assign search_wr_addr = wr_byte;

  assign data       = rd1_data;
  assign valid_data = idle && rd_en && rd1_hit;
  assign store_hit  = idle && wr_en && rd1_hit;

  assign sweep_step = (state == ST_SWEEP) && !fill_valid && !mshr_full;

  // the head retires as its fill is taken, so a victim push always finds a slot
  assign fill_direct = idle && fill_valid && !store_hit;
  // during a flush the array is not refilled, dirty fills go straight back out
  assign fill_flush  = !idle && fill_valid;
  assign fill_taken  = fill_direct || fill_flush;

  assign evict_push = ((sweep_step || (fill_direct && !wr1_hit)) && evicted_valid && evicted_dirty)
                      || (fill_flush && fill_dirty);
  assign store_miss = idle && wr_en && !rd1_hit && !search_wr_hit && !mshr_full && !evict_push;
  assign load_miss  = idle && rd_en && !rd1_hit && !search_rd_hit && !mshr_full && !evict_push;

  // a queued store counts as done
  assign valid_store = store_hit || store_miss;

  // write port: sweep, then store hit, then fill
  always_comb begin
    wr1_en    = sweep_step || store_hit || fill_direct;
    wr1_addr  = fill_addr;
    wr1_data  = fill_data;
    wr1_dirty = fill_dirty;
    wr1_valid = 1'b1;
    if (state == ST_SWEEP) begin
      wr1_addr  = sweep_addr;
      wr1_data  = '0;
      wr1_dirty = 1'b0;
      wr1_valid = 1'b0;
    end else if (store_hit) begin
      wr1_addr  = wr_byte;
      wr1_data  = wr_data;
      wr1_dirty = 1'b1;
    end
  end

  // push: evict, then store miss, then load miss
  always_comb begin
    push_en   = evict_push || store_miss || load_miss;
    push_kind = LOAD;
    push_addr = rd_byte;
    push_data = '0;
    if (fill_flush) begin
      push_kind = EVICT;
      push_addr = fill_addr;
      push_data = fill_data;
    end else if (evict_push) begin
      push_kind = EVICT;
      push_addr = evicted_addr;
      push_data = evicted_data;
    end else if (store_miss) begin
      push_kind = STORE;
      push_addr = wr_byte;
      push_data = wr_data;
    end
  end

  // end-of-program sweep, one line per step, then wait for the queue to drain
  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= ST_IDLE;
      sweep_count <= '0;
      flush_done  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE:
          if (write_back)
            state <= ST_SWEEP;
        ST_SWEEP:
          if (sweep_step) begin
            sweep_count <= sweep_count + dc_index_t'(1);
            if (&sweep_count)
              state <= ST_DONE;
          end
        default:
          if (mshr_empty)
            flush_done <= 1'b1;
      endcase
    end
  end

  assert property (@(posedge clock) disable iff (reset) flush_done |-> !push_en)
    else $error("dcache_controller: queue push after flush_done");

endmodule

`default_nettype wire

// File: dcache_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_mem
  import dcache_addr_pkg::*;
(
  input  wire logic        clock,
  input  wire logic        reset,
  input  wire dc_addr_t    rd1_addr,
  input  wire dc_addr_t    wr1_addr,
  input  wire logic        wr1_en,
  input  wire logic [63:0] wr1_data,
  input  wire logic        wr1_dirty,
  input  wire logic        wr1_valid,
  output logic [63:0]      rd1_data,
  output logic             rd1_hit,
  output logic             wr1_hit,
  output logic             evicted_valid,
  output logic             evicted_dirty,
  output dc_addr_t         evicted_addr,
  output logic [63:0]      evicted_data
);

  dc_tag_t              line_tag  [`DC_LINES];
  logic [63:0]          line_data [`DC_LINES];
  logic [`DC_LINES-1:0] line_valid;
  logic [`DC_LINES-1:0] line_dirty;
  dc_index_t            rd_idx;
  dc_index_t            wr_idx;

  assign rd_idx = rd1_addr.fields.index;
  assign wr_idx = wr1_addr.fields.index;

  // lookup port
  assign rd1_data = line_data[rd_idx];
  assign rd1_hit  = line_valid[rd_idx] && (line_tag[rd_idx] == rd1_addr.fields.tag);

  // write port also reports whatever sits in the target line
  assign wr1_hit       = line_valid[wr_idx] && (line_tag[wr_idx] == wr1_addr.fields.tag);
  assign evicted_valid = line_valid[wr_idx];
  assign evicted_dirty = line_dirty[wr_idx];
  assign evicted_data  = line_data[wr_idx];

  // victim address rebuilt from stored tag and index
  always_comb begin
    evicted_addr              = '0;
    evicted_addr.fields.tag   = line_tag[wr_idx];
    evicted_addr.fields.index = wr_idx;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      line_valid <= '0;
      line_dirty <= '0;
    end else if (wr1_en) begin
      line_valid[wr_idx] <= wr1_valid;
      line_dirty[wr_idx] <= wr1_dirty;
    end
  end

  always_ff @(posedge clock) begin
    if (wr1_en) begin
      line_tag[wr_idx]  <= wr1_addr.fields.tag;
      line_data[wr_idx] <= wr1_data;
    end
  end

  // an invalidated line never comes back dirty
  assert property (@(posedge clock) disable iff (reset)
    wr1_en && !wr1_valid |=> !line_dirty[$past(wr_idx)])
    else $error("dcache_mem: invalidated line left dirty");

endmodule

`default_nettype wire

// File: dcache_mshr.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_mshr
  import dcache_addr_pkg::*;
  import dcache_cmd_pkg::*;
(
  input  wire logic        clock,
  input  wire logic        reset,
  input  wire logic        push_en,
  input  wire mshr_kind_t  push_kind,
  input  wire dc_addr_t    push_addr,
  input  wire logic [63:0] push_data,
  input  wire dc_addr_t    search_rd_addr,
  input  wire dc_addr_t    search_wr_addr,
  input  wire logic        fill_taken,
  input  wire logic [63:0] wb_dat_r,
  input  wire logic        wb_ack,
  output logic             mshr_full,
  output logic             mshr_empty,
  output logic             search_rd_hit,
  output logic             search_wr_hit,
  output logic             fill_valid,
  output dc_addr_t         fill_addr,
  output logic [63:0]      fill_data,
  output logic             fill_dirty,
  output logic             wb_cyc,
  output logic             wb_stb,
  output logic             wb_we,
  output dc_addr_t         wb_adr,
  output logic [63:0]      wb_dat_w
);

  localparam int DEPTH    = `DC_MSHR_DEPTH;
  localparam int PTR_BITS = $clog2(DEPTH);

  localparam logic [1:0] HEAD_START = 2'd0;
  localparam logic [1:0] HEAD_BUS   = 2'd1;
  localparam logic [1:0] HEAD_FILL  = 2'd2;

  mshr_kind_t          ent_kind [DEPTH];
  dc_addr_t            ent_addr [DEPTH];
  logic [63:0]         ent_data [DEPTH];
  logic [DEPTH-1:0]    ent_valid;
  logic [PTR_BITS-1:0] head;
  logic [PTR_BITS-1:0] tail;
  logic [1:0]          head_state;
  logic                pop;

  assign mshr_full  = &ent_valid;
  assign mshr_empty = ~|ent_valid;

  // whole-address compare against every live entry
  always_comb begin
    search_rd_hit = 1'b0;
    search_wr_hit = 1'b0;
    for (int i = 0; i < DEPTH; i++) begin
      if (ent_valid[i] && (ent_addr[i].raw == search_rd_addr.raw))
        search_rd_hit = 1'b1;
      if (ent_valid[i] && (ent_addr[i].raw == search_wr_addr.raw))
        search_wr_hit = 1'b1;
    end
  end

  // head entry drives the bus, then the fill
  assign wb_cyc   = (head_state == HEAD_BUS);
  assign wb_stb   = wb_cyc;
  assign wb_we    = (bus_cmd_of(ent_kind[head]) == BUS_STORE);
  assign wb_adr   = ent_addr[head];
  assign wb_dat_w = ent_data[head];

  assign fill_valid = (head_state == HEAD_FILL);
  assign fill_addr  = ent_addr[head];
  assign fill_data  = ent_data[head];
  assign fill_dirty = (ent_kind[head] == STORE);

  assign pop = (wb_cyc && wb_ack && ent_kind[head] == EVICT) || (fill_valid && fill_taken);

  always_ff @(posedge clock) begin
    if (reset) begin
      head       <= '0;
      tail       <= '0;
      ent_valid  <= '0;
      head_state <= HEAD_START;
    end else begin
      if (pop) begin
        ent_valid[head] <= 1'b0;
        head            <= head + PTR_BITS'(1);
      end
      // when full, a push lands in the slot the head is leaving
      if (push_en) begin
        ent_valid[tail] <= 1'b1;
        tail            <= tail + PTR_BITS'(1);
      end
      case (head_state)
        HEAD_START:
          if (ent_valid[head])
            head_state <= (ent_kind[head] == STORE) ? HEAD_FILL : HEAD_BUS;
        HEAD_BUS:
          if (wb_ack)
            head_state <= (ent_kind[head] == EVICT) ? HEAD_START : HEAD_FILL;
        HEAD_FILL:
          if (fill_taken)
            head_state <= HEAD_START;
        default:
          head_state <= HEAD_START;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    // load data returns into the head entry
    if (wb_cyc && wb_ack && ent_kind[head] == LOAD)
      ent_data[head] <= wb_dat_r;
    if (push_en) begin
      ent_kind[tail] <= push_kind;
      ent_addr[tail] <= push_addr;
      ent_data[tail] <= push_data;
    end
  end

  assert property (@(posedge clock) disable iff (reset) push_en && mshr_full |-> pop)
    else $error("dcache_mshr: push into a full queue");

  assert property (@(posedge clock) disable iff (reset)
    wb_stb |-> wb_cyc && ent_valid[head] && ent_kind[head] != STORE)
    else $error("dcache_mshr: strobe without a bus entry at the head");

  assert property (@(posedge clock) disable iff (reset)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr.raw) && $stable(wb_dat_w))
    else $error("dcache_mshr: bus request changed before ack");

endmodule

`default_nettype wire

// File: dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_tb;

  localparam int AW       = `DC_WORD_ADDR_BITS;
  localparam int WORDS    = 1 << AW;
  localparam int MAX_ROWS = 32;
  localparam logic [1:0] OP_LOAD  = 2'd0;
  localparam logic [1:0] OP_STORE = 2'd1;
  localparam logic [1:0] OP_WCHK  = 2'd2;
  localparam logic [1:0] OP_FLUSH = 2'd3;

  logic          clock;
  logic          reset;
  logic          rd_en;
  logic          wr_en;
  logic [AW-1:0] rd_addr;
  logic [AW-1:0] wr_addr;
  logic [63:0]   wr_data;
  logic [63:0]   data;
  logic          valid_data;
  logic          valid_store;
  logic          write_back;
  logic          flush_done;
  logic          wb_cyc;
  logic          wb_stb;
  logic          wb_we;
  logic [15:0]   wb_adr;
  logic [63:0]   wb_dat_w;
  logic [63:0]   wb_dat_r;
  logic          wb_ack;

  // operation table, expected load data filled in at start
  logic [1:0]    row_op   [MAX_ROWS];
  logic [AW-1:0] row_addr [MAX_ROWS];
  logic [63:0]   row_data [MAX_ROWS];
  logic [63:0]   row_exp  [MAX_ROWS];
  bit            row_hit  [MAX_ROWS];
  int            num_rows;

  // memory behind the bus and the reference copy
  logic [63:0] model_mem  [WORDS];
  logic [63:0] expect_mem [WORDS];
  bit          touched    [WORDS];
  bit          wr_seen    [WORDS];
  logic [63:0] wr_last    [WORDS];

  bit          busy;
  logic [1:0]  wait_left;
  logic [15:0] held_adr;
  logic [63:0] held_dat;
  logic        held_we;
  logic [31:0] rand_state;
  int          cycle_count;
  int          limit_cycles;

  dcache_top dut (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  function automatic logic [63:0] fill_word(input logic [AW-1:0] wa);
    return 64'({wa, 3'b000}) ^ 64'h5A5A_C3C3_0F0F_9696;
  endfunction

  // lcg, upper bits give the ack delay
  function automatic logic [1:0] next_wait();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return rand_state[17:16];
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic add_row(input logic [1:0] op, input logic [AW-1:0] addr,
                         input logic [63:0] wdata, input bit hit);
    row_op[num_rows]   = op;
    row_addr[num_rows] = addr;
    row_data[num_rows] = wdata;
    row_hit[num_rows]  = hit;
    row_exp[num_rows]  = '0;
    num_rows++;
  endtask

  task automatic load_word(input int r);
    int waited;
    waited  = 0;
    rd_en   = 1'b1;
    rd_addr = row_addr[r];
    @(negedge clock);
    while (!valid_data) begin
      @(negedge clock);
      waited++;
    end
    assert (data === row_exp[r])
      else stop_run($sformatf("MISMATCH data row %0d: got %h expected %h",
                              r, data, row_exp[r]));
    assert (!row_hit[r] || waited == 0)
      else stop_run($sformatf("row %0d should hit but waited %0d cycles", r, waited));
    @(posedge clock);
    #1;
    rd_en = 1'b0;
  endtask

  task automatic store_word(input int r);
    wr_en   = 1'b1;
    wr_addr = row_addr[r];
    wr_data = row_data[r];
    @(negedge clock);
    while (!valid_store)
      @(negedge clock);
    @(posedge clock);
    #1;
    wr_en = 1'b0;
  endtask

  // the victim must have gone out on the bus with its stored data
  task automatic check_evict_write(input int r);
    assert (wr_seen[row_addr[r]])
      else stop_run($sformatf("no Wishbone write seen for word %h", row_addr[r]));
    assert (wr_last[row_addr[r]] === row_exp[r])
      else stop_run($sformatf("MISMATCH wb_dat_w word %h: got %h expected %h",
                              row_addr[r], wr_last[row_addr[r]], row_exp[r]));
  endtask

  task automatic flush_and_compare();
    write_back = 1'b1;
    @(posedge clock);
    #1;
    write_back = 1'b0;
    @(negedge clock);
    while (!flush_done)
      @(negedge clock);
    repeat (20) begin
      @(negedge clock);
      assert (!wb_cyc) else stop_run("Wishbone cycle started after flush_done");
    end
    for (int a = 0; a < WORDS; a++) begin
      if (touched[a])
        assert (model_mem[a] === expect_mem[a])
          else stop_run($sformatf("MISMATCH model_mem[%h]: got %h expected %h",
                                  a, model_mem[a], expect_mem[a]));
    end
  endtask

  // wishbone slave, 0 to 3 wait cycles per access
  initial begin
    forever begin
      @(posedge clock);
      #1;
      if (wb_ack) begin
        wb_ack = 1'b0;
        busy   = 1'b0;
      end else if (wb_stb) begin
        if (!busy) begin
          busy      = 1'b1;
          wait_left = next_wait();
          held_adr  = wb_adr;
          held_dat  = wb_dat_w;
          held_we   = wb_we;
        end
        assert (wb_adr === held_adr)
          else stop_run($sformatf("MISMATCH wb_adr: got %h held %h", wb_adr, held_adr));
        assert (wb_dat_w === held_dat && wb_we === held_we)
          else stop_run($sformatf("MISMATCH wb_dat_w: got %h held %h", wb_dat_w, held_dat));
        if (wait_left == 2'd0) begin
          if (held_we) begin
            model_mem[held_adr[15:3]] = held_dat;
            wr_seen[held_adr[15:3]]   = 1'b1;
            wr_last[held_adr[15:3]]   = held_dat;
          end else begin
            wb_dat_r = model_mem[held_adr[15:3]];
          end
          wb_ack = 1'b1;
        end else begin
          wait_left = wait_left - 2'd1;
        end
      end
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= limit_cycles)
      stop_run($sformatf("timeout: run did not finish within %0d cycles", limit_cycles));
  end

  initial begin
    reset        = 1'b1;
    rd_en        = 1'b0;
    wr_en        = 1'b0;
    rd_addr      = '0;
    wr_addr      = '0;
    wr_data      = '0;
    write_back   = 1'b0;
    wb_ack       = 1'b0;
    wb_dat_r     = '0;
    busy         = 1'b0;
    wait_left    = '0;
    held_adr     = '0;
    held_dat     = '0;
    held_we      = 1'b0;
    rand_state   = 32'd68;
    cycle_count  = 0;
    num_rows     = 0;
    limit_cycles = 16 * 80;
    for (int a = 0; a < WORDS; a++) begin
      model_mem[a]  = fill_word(AW'(a));
      expect_mem[a] = model_mem[a];
      touched[a]    = 1'b0;
      wr_seen[a]    = 1'b0;
      wr_last[a]    = '0;
    end
    // miss, then hits, then store hit and store miss
    add_row(OP_LOAD,  13'h010, 64'h0, 1'b0);
    add_row(OP_LOAD,  13'h010, 64'h0, 1'b1);
    add_row(OP_STORE, 13'h010, 64'hD00D_0000_0000_0010, 1'b0);
    add_row(OP_LOAD,  13'h010, 64'h0, 1'b1);
    add_row(OP_STORE, 13'h123, 64'hD11D_0000_0000_0123, 1'b0);
    add_row(OP_LOAD,  13'h123, 64'h0, 1'b0);
    // same index 5, the dirty victim goes out on the bus
    add_row(OP_STORE, 13'h045, 64'hD22D_0000_0000_0045, 1'b0);
    add_row(OP_STORE, 13'h145, 64'hD33D_0000_0000_0145, 1'b0);
    add_row(OP_LOAD,  13'h145, 64'h0, 1'b0);
    add_row(OP_LOAD,  13'h045, 64'h0, 1'b0);
    add_row(OP_WCHK,  13'h045, 64'h0, 1'b0);
    // clean replacements
    add_row(OP_LOAD,  13'h1F7, 64'h0, 1'b0);
    add_row(OP_LOAD,  13'h0A7, 64'h0, 1'b0);
    add_row(OP_LOAD,  13'h1F7, 64'h0, 1'b0);
    // enough store misses to fill the queue
    add_row(OP_STORE, 13'h201, 64'hA000_0000_0000_0201, 1'b0);
    add_row(OP_STORE, 13'h202, 64'hA000_0000_0000_0202, 1'b0);
    add_row(OP_STORE, 13'h206, 64'hA000_0000_0000_0206, 1'b0);
    add_row(OP_STORE, 13'h208, 64'hA000_0000_0000_0208, 1'b0);
    add_row(OP_STORE, 13'h209, 64'hA000_0000_0000_0209, 1'b0);
    add_row(OP_STORE, 13'h0FF, 64'hB000_0000_0000_00FF, 1'b0);
    add_row(OP_STORE, 13'h2FF, 64'hB000_0000_0000_02FF, 1'b0);
    add_row(OP_STORE, 13'h3FF, 64'hB000_0000_0000_03FF, 1'b0);
    add_row(OP_LOAD,  13'h2FF, 64'h0, 1'b0);
    add_row(OP_LOAD,  13'h0FF, 64'h0, 1'b0);
    add_row(OP_STORE, 13'h123, 64'hD44D_0000_0000_0123, 1'b0);
    add_row(OP_LOAD,  13'h123, 64'h0, 1'b1);
    add_row(OP_FLUSH, 13'h000, 64'h0, 1'b0);
    for (int r = 0; r < num_rows; r++) begin
      if (row_op[r] != OP_FLUSH)
        touched[row_addr[r]] = 1'b1;
      if (row_op[r] == OP_STORE)
        expect_mem[row_addr[r]] = row_data[r];
      row_exp[r] = expect_mem[row_addr[r]];
    end
    limit_cycles = (num_rows + 16) * 80;
    repeat (8) @(posedge clock);
    #1;
    reset = 1'b0;
    for (int r = 0; r < num_rows; r++) begin
      case (row_op[r])
        OP_LOAD:  load_word(r);
        OP_STORE: store_word(r);
        OP_WCHK:  check_evict_write(r);
        default:  flush_and_compare();
      endcase
    end
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_top
  import dcache_addr_pkg::*;
  import dcache_cmd_pkg::*;
(
  input  wire logic                          clock,
  input  wire logic                          reset,
  input  wire logic                          rd_en,
  input  wire logic                          wr_en,
  input  wire logic [`DC_WORD_ADDR_BITS-1:0] rd_addr,
  input  wire logic [`DC_WORD_ADDR_BITS-1:0] wr_addr,
  input  wire logic [63:0]                   wr_data,
  output logic [63:0]                        data,
  output logic                               valid_data,
  output logic                               valid_store,
  input  wire logic                          write_back,
  output logic                               flush_done,
  output logic                               wb_cyc,
  output logic                               wb_stb,
  output logic                               wb_we,
  output dc_addr_t                           wb_adr,
  output logic [63:0]                        wb_dat_w,
  input  wire logic [63:0]                   wb_dat_r,
  input  wire logic                          wb_ack
);

  // array ports
  dc_addr_t    rd1_addr, wr1_addr, evicted_addr;
  logic [63:0] rd1_data, wr1_data, evicted_data;
  logic        rd1_hit, wr1_hit, evicted_valid, evicted_dirty;
  logic        wr1_en, wr1_dirty, wr1_valid;

  // miss queue ports
  logic        push_en, mshr_full, mshr_empty;
  mshr_kind_t  push_kind;
  dc_addr_t    push_addr, search_rd_addr, search_wr_addr, fill_addr;
  logic [63:0] push_data, fill_data;
  logic        search_rd_hit, search_wr_hit;
  logic        fill_valid, fill_dirty, fill_taken;

  dcache_controller controller (.*);

  dcache_mem mem (.*);

  dcache_mshr mshr (.*);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f verilog.f --top-module dcache_tb -o dcache_sim
./obj_dir/dcache_sim > sim.log 2>&1 || true
cat sim.log
if grep -qx "All checks passed" sim.log; then
  exit 0
fi
exit 1

// File: verilog.f
+incdir+.
dcache_addr_pkg.sv
dcache_cmd_pkg.sv
dcache_mem.sv
dcache_mshr.sv
dcache_controller.sv
dcache_top.sv
dcache_tb.sv
